/* rtl/cd_pkg.sv */
// Shared constants for the receive path of the multi-drop bus controller.
// Imported by every RTL module that needs byte, CRC or frame limits.

package cd_pkg;

    // data path
    localparam int BYTE_W = 8;                  // width of one bus byte

    // CRC-16, reflected form, appended low byte first
    localparam logic [15:0] CRC_INIT = 16'hffff; // preset at frame start
    localparam logic [15:0] CRC_POLY = 16'ha001; // reflected 0x8005

    // frame limits, CRC bytes included
    localparam int MAX_FRAME = 256;             // longest frame that is stored
    localparam int MIN_FRAME = 3;               // header byte plus two CRC bytes

endpackage

/* rtl/cd_sdpram.sv */
// Simple dual-port byte RAM: one synchronous write port and one registered read port.
// Both strobes are active low; cen must be low for either port to act.

module cd_sdpram
    import cd_pkg::*;
#(
    parameter int A_WIDTH = 11
) (
    input  logic               clk,
    input  logic               cen,     // chip enable, active low
    input  logic [A_WIDTH-1:0] ra,
    output logic [BYTE_W-1:0]  rd,
    input  logic [A_WIDTH-1:0] wa,
    input  logic [BYTE_W-1:0]  wd,
    input  logic               wen      // write enable, active low
);

    logic [BYTE_W-1:0] mem [2**A_WIDTH];

    always_ff @(posedge clk) begin
        if (!cen) begin
            rd <= mem[ra];              // data appears one cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (!cen && !wen) begin
            mem[wa] <= wd;
        end
    end

    // the read address is sampled on every enabled cycle, reads and writes alike
    ra_known: assert property (@(posedge clk) !cen |-> !$isunknown(ra))
        else $error("sdpram: unknown read address while enabled");

    wa_known: assert property (@(posedge clk) (!cen && !wen) |-> !$isunknown(wa))
        else $error("sdpram: unknown write address on write");

endmodule

/* rtl/cd_crc16.sv */
// Running CRC-16 (reflected, polynomial 0xA001) over the bytes of one frame.
// clear reloads the preset; crc_ok is high when the residue is zero, i.e. the
// frame including its low-byte-first CRC was received intact.

module cd_crc16
    import cd_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              clear,    // frame start
    input  logic              strobe,   // one byte to fold in
    input  logic [BYTE_W-1:0] data,
    output logic              crc_ok
);

    logic [15:0] crc_q;

    // one byte folded in, lsb first, eight shift steps
    function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [BYTE_W-1:0] d);
        logic [15:0] r;
        r = c ^ {{(16 - BYTE_W){1'b0}}, d};
        for (int i = 0; i < BYTE_W; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_q <= CRC_INIT;
        end else if (clear && strobe) begin
            crc_q <= crc_byte(CRC_INIT, data);   // first byte of a new frame
        end else if (clear) begin
            crc_q <= CRC_INIT;
        end else if (strobe) begin
            crc_q <= crc_byte(crc_q, data);
        end
    end

    assign crc_ok = (crc_q == 16'h0000);

endmodule

/* rtl/cd_rx_framer.sv */
// Receive framer: turns byte strobes from the receiver into frame buffer writes.
// Tracks the byte position, drives the CRC block and, on rx_end, reports the
// frame length and error status with a one-cycle switch pulse.

module cd_rx_framer
    import cd_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,

    input  logic [BYTE_W-1:0]            rx_byte,
    input  logic                         rx_strobe,
    input  logic                         rx_end,     // line idle after a frame
    input  logic                         rx_abort,   // framing or bit error

    output logic                         crc_clear,
    output logic                         crc_strobe,
    output logic [BYTE_W-1:0]            crc_data,
    input  logic                         crc_ok,

    output logic [BYTE_W-1:0]            wr_byte,
    output logic [$clog2(MAX_FRAME)-1:0] wr_addr,    // offset within the frame
    output logic                         wr_en,
    output logic [$clog2(MAX_FRAME)-1:0] wr_len,     // frame length minus one
    output logic                         wr_err,
    output logic                         switch
);

    localparam int L_WIDTH = $clog2(MAX_FRAME);
    localparam int C_WIDTH = $clog2(MAX_FRAME + 1);

    logic [C_WIDTH-1:0] cnt;            // bytes accepted so far
    logic               in_frame;
    logic               abort_seen;     // sticky until the next frame
    logic               overflow;       // more than MAX_FRAME bytes arrived
    logic               accept;
    logic               frame_done;
    logic               frame_bad;
    logic [L_WIDTH-1:0] byte_pos;
    logic [C_WIDTH-1:0] len_m1;

    // bytes past MAX_FRAME still go through the CRC but are not stored
    assign accept     = rx_strobe && (!in_frame || cnt < MAX_FRAME);
    assign frame_done = rx_end && in_frame;
    assign byte_pos   = in_frame ? cnt[L_WIDTH-1:0] : '0;
    assign len_m1     = cnt - 1'b1;

    assign frame_bad = !crc_ok || (cnt < MIN_FRAME) || overflow || abort_seen || rx_abort;

    assign crc_clear  = rx_strobe && !in_frame;
    assign crc_strobe = rx_strobe;
    assign crc_data   = rx_byte;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt        <= '0;
            in_frame   <= 1'b0;
            abort_seen <= 1'b0;
            overflow   <= 1'b0;
            wr_en      <= 1'b0;
            switch     <= 1'b0;
        end else begin
            wr_en  <= accept;
            switch <= frame_done;       // empty frames never get here

            if (rx_strobe) begin
                if (!in_frame) begin
                    in_frame   <= 1'b1;
                    cnt        <= C_WIDTH'(1);
                    abort_seen <= rx_abort;
                    overflow   <= 1'b0;
                end else if (cnt < MAX_FRAME) begin
                    cnt <= cnt + 1'b1;
                end else begin
                    overflow <= 1'b1;
                end
            end else if (rx_end) begin
                in_frame <= 1'b0;
            end

            if (rx_abort && in_frame) begin
                abort_seen <= 1'b1;
            end
        end
    end

    // length and error hold until the next frame ends, the buffer samples them late
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_byte <= rx_byte;
            wr_addr <= byte_pos;
        end
        if (frame_done) begin
            wr_len <= len_m1[L_WIDTH-1:0];
            wr_err <= frame_bad;
        end
    end

    // relies on the receiver never ending a frame in the same cycle as a byte
    no_switch_on_write: assert property (
        @(posedge clk) disable iff (!reset_n) switch |-> !wr_en
    ) else $error("framer: switch raised while a byte write is pending");

endmodule

/* rtl/cd_rx_ram.sv */
// Multi-frame receive buffer built as a ring of 2^I_WIDTH blocks of 2^(B_WIDTH-I_WIDTH) bytes.
// The framer writes one frame at the write index and commits it on switch; the host
// reads frames back in arrival order and releases each one with rd_done.

module cd_rx_ram
    import cd_pkg::*;
#(
    parameter int I_WIDTH = 6,          // 64 index entries
    parameter int B_WIDTH = 11          // 2048 bytes of storage
) (
    input  logic                         clk,
    input  logic                         reset_n,

    output logic [BYTE_W-1:0]            rd_byte,
    input  logic [$clog2(MAX_FRAME)-1:0] rd_addr,
    input  logic                         rd_en,
    input  logic                         rd_done,
    input  logic                         rd_done_all,
    output logic                         unread,
    output logic [$clog2(MAX_FRAME)-1:0] rd_len,     // frame length incl. CRC minus one
    output logic                         rd_err,

    input  logic [BYTE_W-1:0]            wr_byte,
    input  logic [$clog2(MAX_FRAME)-1:0] wr_addr,
    input  logic                         wr_en,
    input  logic                         wr_err,
    input  logic [$clog2(MAX_FRAME)-1:0] wr_len,
    input  logic                         switch,
    output logic                         switch_fail
);

    localparam int L_WIDTH = $clog2(MAX_FRAME);
    localparam int S_WIDTH = B_WIDTH - I_WIDTH;  // log2 of bytes per block
    localparam int F_WIDTH = L_WIDTH - S_WIDTH;  // log2 of extra blocks per frame
    localparam int BLOCKS  = 2 ** I_WIDTH;

    logic [I_WIDTH-1:0]         wr_sel;          // first block of the frame being written
    logic [I_WIDTH-1:0]         rd_sel;          // first block of the frame being read
    logic [BLOCKS-1:0]          dirty;           // set on a frame's head block
    logic [BLOCKS-1:0]          error;

    logic                       wr_cancel;       // frame hit an unread block
    logic                       wr_en_d;
    logic                       wr_err_d;
    logic                       switch_d;
    logic [F_WIDTH-1:0]         wr_frag_amount;  // highest block offset written
    logic                       commit;

    logic [B_WIDTH-1:0]         buf_wr_addr;
    logic [BYTE_W-1:0]          wr_byte_d;       // byte held with its address
    logic [B_WIDTH-1:0]         buf_rd_addr;
    logic [I_WIDTH-1:0]         wr_blk;          // block the incoming byte lands in

    // index entry holds {extra block count, length}
    logic [F_WIDTH+L_WIDTH-1:0] idx_table [BLOCKS];
    logic [F_WIDTH+L_WIDTH-1:0] idx_rd_val;
    logic [F_WIDTH-1:0]         rd_frag_amount;

    assign unread = dirty[rd_sel];
    assign rd_err = error[rd_sel];

    assign rd_len         = idx_rd_val[L_WIDTH-1:0];
    assign rd_frag_amount = idx_rd_val[L_WIDTH +: F_WIDTH];

    // the sum wraps at the end of the buffer, so frames may cross block 0
    assign buf_rd_addr = {rd_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(rd_addr);
    assign wr_blk      = wr_sel + I_WIDTH'(wr_addr[L_WIDTH-1:S_WIDTH]);
    assign commit      = switch_d && !wr_cancel;

    cd_sdpram #(
        .A_WIDTH (B_WIDTH)
    ) cd_sdpram_i (
        .clk (clk),
        .cen (~(rd_en | wr_en_d)),
        .ra  (buf_rd_addr),
        .rd  (rd_byte),
        .wa  (buf_wr_addr),
        .wd  (wr_byte_d),
        .wen (~wr_en_d)
    );

    always_ff @(posedge clk) begin
        buf_wr_addr <= {wr_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(wr_addr);
        wr_byte_d   <= wr_byte;
        wr_err_d    <= wr_err;
        idx_rd_val  <= idx_table[rd_sel];    // rd_len follows rd_sel one cycle later
        if (commit) begin
            idx_table[wr_sel] <= {wr_frag_amount, wr_len};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            switch_fail    <= 1'b0;
            rd_sel         <= '0;
            wr_sel         <= '0;
            dirty          <= '0;
            error          <= '0;
            wr_cancel      <= 1'b0;
            wr_en_d        <= 1'b0;
            wr_frag_amount <= '0;
            switch_d       <= 1'b0;
        end else begin
            switch_fail <= 1'b0;
            wr_en_d     <= 1'b0;
            switch_d    <= switch;

            if (wr_en && !wr_cancel) begin
                if (dirty[wr_blk]) begin
                    wr_cancel <= 1'b1;           // drop the rest of this frame
                end else begin
                    wr_en_d        <= 1'b1;
                    wr_frag_amount <= wr_addr[L_WIDTH-1:S_WIDTH];
                end
            end

            if (switch_d) begin
                if (wr_cancel) begin
                    switch_fail <= 1'b1;
                end else begin
                    error[wr_sel] <= wr_err_d;
                    dirty[wr_sel] <= 1'b1;
                    wr_sel        <= wr_sel + I_WIDTH'(wr_frag_amount) + 1'b1;
                end
                wr_cancel <= 1'b0;
            end

            if (rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + I_WIDTH'(rd_frag_amount) + 1'b1;
            end

            // host flush wins over anything else in the same cycle
            if (rd_done_all) begin
                switch_fail <= 1'b0;
                rd_sel      <= '0;
                wr_sel      <= '0;
                dirty       <= '0;
                wr_cancel   <= 1'b0;
                switch_d    <= 1'b0;
            end
        end
    end

    // the host may only release a frame that it has been offered
    done_when_unread: assert property (
        @(posedge clk) disable iff (!reset_n) rd_done |-> unread
    ) else $error("rx_ram: rd_done without an unread frame");

endmodule

/* rtl/cd_rx_top.sv */
// Receive path top level: framer, CRC checker and multi-frame buffer.
// Byte strobes come in from the receiver; the host reads frames out by offset.

module cd_rx_top
    import cd_pkg::*;
#(
    parameter int I_WIDTH = 6,
    parameter int B_WIDTH = 11
) (
    input  logic                         clk,
    input  logic                         reset_n,

    input  logic [BYTE_W-1:0]            rx_byte,
    input  logic                         rx_strobe,
    input  logic                         rx_end,
    input  logic                         rx_abort,

    input  logic [$clog2(MAX_FRAME)-1:0] rd_addr,
    input  logic                         rd_en,
    input  logic                         rd_done,
    input  logic                         rd_done_all,
    output logic [BYTE_W-1:0]            rd_byte,
    output logic [$clog2(MAX_FRAME)-1:0] rd_len,
    output logic                         rd_err,
    output logic                         unread,
    output logic                         switch_fail
);

    logic                         crc_clear;
    logic                         crc_strobe;
    logic [BYTE_W-1:0]            crc_data;
    logic                         crc_ok;

    logic [BYTE_W-1:0]            wr_byte;
    logic [$clog2(MAX_FRAME)-1:0] wr_addr;
    logic                         wr_en;
    logic [$clog2(MAX_FRAME)-1:0] wr_len;
    logic                         wr_err;
    logic                         switch;

    cd_rx_framer cd_rx_framer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .rx_end     (rx_end),
        .rx_abort   (rx_abort),
        .crc_clear  (crc_clear),
        .crc_strobe (crc_strobe),
        .crc_data   (crc_data),
        .crc_ok     (crc_ok),
        .wr_byte    (wr_byte),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en),
        .wr_len     (wr_len),
        .wr_err     (wr_err),
        .switch     (switch)
    );

    cd_crc16 cd_crc16_i (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (crc_clear),
        .strobe  (crc_strobe),
        .data    (crc_data),
        .crc_ok  (crc_ok)
    );

    cd_rx_ram #(
        .I_WIDTH (I_WIDTH),
        .B_WIDTH (B_WIDTH)
    ) cd_rx_ram_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_byte     (rd_byte),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (rd_done_all),
        .unread      (unread),
        .rd_len      (rd_len),
        .rd_err      (rd_err),
        .wr_byte     (wr_byte),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .wr_err      (wr_err),
        .wr_len      (wr_len),
        .switch      (switch),
        .switch_fail (switch_fail)
    );

endmodule

/* verification/cd_rx_checker.sv */
// Checker for the receive path: watches the DUT ports, rebuilds each sent frame,
// models the block ring and compares rd_len, rd_err, read bytes and switch_fail.

module cd_rx_checker (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_strobe,
    input  logic       rx_end,
    input  logic [7:0] rd_addr,
    input  logic       rd_en,
    input  logic       rd_done,
    input  logic       rd_done_all,
    input  logic [7:0] rd_byte,
    input  logic [7:0] rd_len,
    input  logic       rd_err,
    input  logic       unread,
    input  logic       switch_fail,
    input  logic       exp_err,     // error expected for the frame being sent
    input  logic       exp_fail,    // table says this frame overflows
    input  logic       final_check,
    output int         errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] cur_q[$];           // bytes of the frame on the line
    logic [7:0] data_q[$];          // committed frames, back to back
    int         len_q[$];
    bit         err_q[$];
    int         blk_q[$];           // blocks per committed frame
    bit         head_dirty[64];
    int         wr_idx = 0;
    int         rd_idx = 0;
    int         pend_fail = 0;
    bit         rd_pending = 0;
    int         pend_addr = 0;
    bit         hdr_done = 0;
    bit         empty_chk = 0;

    initial errors = 0;

    task automatic mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    // length rounds up to whole 32-byte blocks; any dirty head in the way drops the frame
    task automatic end_frame();
        int len;
        int nblk;
        bit fail;
        len = cur_q.size();
        nblk = (len + 31) / 32;
        fail = 0;
        for (int b = 0; b < nblk; b++) begin
            if (head_dirty[(wr_idx + b) % 64]) fail = 1;
        end
        if (fail != exp_fail) mismatch($sformatf("overflow model %0d, table %0d", fail, exp_fail));
        if (fail) begin
            pend_fail++;
        end else begin
            head_dirty[wr_idx] = 1;
            blk_q.push_back(nblk);
            wr_idx = (wr_idx + nblk) % 64;
            foreach (cur_q[i]) data_q.push_back(cur_q[i]);
            len_q.push_back(len);
            err_q.push_back(exp_err);
        end
        cur_q.delete();
    endtask

    task automatic release_frame();
        int len;
        len = len_q.pop_front();
        void'(err_q.pop_front());
        head_dirty[rd_idx] = 0;
        rd_idx = (rd_idx + blk_q.pop_front()) % 64;
        repeat (len) void'(data_q.pop_front());
        hdr_done = 0;
        if (len_q.size() == 0) empty_chk = 1;
    endtask

    always @(posedge clk) begin
        if (reset_n) begin
            if (empty_chk && unread) mismatch("unread still high with no frame left");
            empty_chk = 0;
            if (rd_pending && rd_byte !== data_q[pend_addr]) begin
                mismatch($sformatf("byte %0d read %h, expected %h", pend_addr, rd_byte,
                                   data_q[pend_addr]));
            end
            rd_pending = 0;
            if (rx_strobe) cur_q.push_back(rx_byte);
            if (rx_end && cur_q.size() > 0) end_frame();
            if (rd_en && unread) begin
                if (len_q.size() == 0) begin
                    mismatch("read while no frame is expected");
                end else begin
                    if (!hdr_done) begin
                        if (rd_len !== 8'(len_q[0] - 1)) begin
                            mismatch($sformatf("rd_len %0d, expected %0d", rd_len, len_q[0] - 1));
                        end
                        if (rd_err !== err_q[0]) mismatch($sformatf("rd_err %b, expected %b",
                                                                    rd_err, err_q[0]));
                        hdr_done = 1;
                    end
                    rd_pending = 1;
                    pend_addr = rd_addr;
                end
            end
            if (rd_done && unread && len_q.size() > 0) release_frame();
            if (rd_done_all) begin
                data_q.delete();
                len_q.delete();
                err_q.delete();
                blk_q.delete();
                foreach (head_dirty[i]) head_dirty[i] = 0;
                wr_idx = 0;
                rd_idx = 0;
                hdr_done = 0;
                empty_chk = 1;
            end
            if (switch_fail) begin
                if (pend_fail == 0) mismatch("unexpected switch_fail pulse");
                else pend_fail--;
            end
            if (final_check && (pend_fail != 0 || len_q.size() != 0)) begin
                mismatch($sformatf("%0d switch_fail missing, %0d frames unread",
                                   pend_fail, len_q.size()));
            end
        end
    end

endmodule

/* verification/tb_cd_rx.sv */
// Testbench top for the receive path. Sends the frames of a table with
// xorshift payloads and CRC, and reads them back as the host.

module tb_cd_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = 19;
    // payload length, corrupt, abort, read after, expected switch_fail, flush after
    localparam int PLEN[N]    = '{18, 40, 0, 10, 50, 198, 5, 254, 254, 254, 254,
                                  254, 254, 254, 254, 254, 30, 12, 25};
    localparam bit CORRUPT[N] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    localparam bit ABORT[N]   = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
    localparam bit READ[N]    = '{1, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1};
    localparam bit FAIL[N]    = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
    localparam bit FLUSH[N]   = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0};

    logic       clk;
    logic       reset_n;
    logic [7:0] rx_byte;
    logic       rx_strobe;
    logic       rx_end;
    logic       rx_abort;
    logic [7:0] rd_addr;
    logic       rd_en;
    logic       rd_done;
    logic       rd_done_all;
    logic [7:0] rd_byte;
    logic [7:0] rd_len;
    logic       rd_err;
    logic       unread;
    logic       switch_fail;
    logic       exp_err;
    logic       exp_fail;
    logic       final_check;
    int         errors;
    int         timeouts = 0;
    logic [31:0] rng = 32'h276f;
    int         pend_q[$];          // lengths of frames waiting for the host

    cd_rx_top cd_rx_top_i (.*);

    cd_rx_checker checker_i (.*);

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] crc_next(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] r;
        r = c ^ {8'h00, d};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ 16'ha001) : (r >> 1);
        end
        return r;
    endfunction

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic send_frame(input int plen, input bit corrupt, input bit abort, input bit fail);
        logic [7:0] bytes[$];
        logic [15:0] crc;
        crc = 16'hffff;
        for (int i = 0; i < plen; i++) begin
            rng = xorshift(rng);
            bytes.push_back(rng[7:0]);
            crc = crc_next(crc, rng[7:0]);
        end
        bytes.push_back(crc[7:0]);             // low byte first
        bytes.push_back(crc[15:8]);
        if (corrupt) bytes[0] = bytes[0] ^ 8'h5a;
        exp_err = corrupt || abort || (plen + 2 < 3);
        exp_fail = fail;
        foreach (bytes[i]) begin
            @(posedge clk);
            #2;
            rx_abort = 0;
            rx_byte = bytes[i];
            rx_strobe = 1;
            @(posedge clk);
            #2;
            rx_strobe = 0;
            rx_abort = abort && (i == 1);      // abort lands in a gap mid frame
        end
        @(posedge clk);
        #2;
        rx_abort = 0;
        rx_end = 1;
        @(posedge clk);
        #2;
        rx_end = 0;
        repeat (6) @(posedge clk);             // let the commit settle
        if (!fail) pend_q.push_back(plen + 2);
    endtask

    task automatic wait_unread(output bit seen);
        seen = 0;
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            #1;
            if (unread) begin
                seen = 1;
                return;
            end
        end
        $display("timeout: unread did not rise for a queued frame");
        timeouts++;
    endtask

    task automatic read_frame(input int len);
        bit seen;
        wait_unread(seen);
        if (!seen) return;
        repeat (2) @(posedge clk);             // rd_len follows the index one cycle late
        for (int a = 0; a < len; a++) begin
            #2;
            rd_en = 1;
            rd_addr = a[7:0];
            @(posedge clk);
        end
        #2;
        rd_en = 0;
        @(posedge clk);
        #2;
        rd_done = 1;
        @(posedge clk);
        #2;
        rd_done = 0;
    endtask

    initial begin
        reset_n = 0;
        rx_byte = '0;
        rx_strobe = 0;
        rx_end = 0;
        rx_abort = 0;
        rd_addr = '0;
        rd_en = 0;
        rd_done = 0;
        rd_done_all = 0;
        exp_err = 0;
        exp_fail = 0;
        final_check = 0;
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1;
        for (int e = 0; e < N && timeouts == 0; e++) begin
            send_frame(PLEN[e], CORRUPT[e], ABORT[e], FAIL[e]);
            if (READ[e]) begin
                while (pend_q.size() > 0 && timeouts == 0) read_frame(pend_q.pop_front());
            end
            if (FLUSH[e]) begin
                @(posedge clk);
                #2;
                rd_done_all = 1;
                @(posedge clk);
                #2;
                rd_done_all = 0;
                pend_q.delete();
            end
        end
        repeat (5) @(posedge clk);
        #2;
        final_check = 1;
        @(posedge clk);
        #2;
        final_check = 0;
        @(posedge clk);
        finish_run();
    end

endmodule

/* flist.f */
rtl/cd_pkg.sv
rtl/cd_sdpram.sv
rtl/cd_crc16.sv
rtl/cd_rx_framer.sv
rtl/cd_rx_ram.sv
rtl/cd_rx_top.sv
verification/cd_rx_checker.sv
verification/tb_cd_rx.sv
